// ==== design/axil_fifo_defs.svh ====
`ifndef AXIL_FIFO_DEFS_SVH
`define AXIL_FIFO_DEFS_SVH

// stream word layout
`define AXF_DATA_WIDTH 16
`define AXF_USER_WIDTH 1

// fifo depth, power of two only
`define AXF_FIFO_LEN 8

// axi-lite byte address width
`define AXF_ADDR_WIDTH 16

// identity registers
`define AXF_CORE_ID 32'd0
`define AXF_VERSION 32'h00010069

// "FIFO" in ascii
`define AXF_MAGIC 32'h4649464F

`define AXF_PATTERN 32'h69696969

`endif

// ==== design/axil_fifo_pkg.sv ====
`include "axil_fifo_defs.svh"

package axil_fifo_pkg;

    // word addresses of the register map
    typedef enum logic [`AXF_ADDR_WIDTH-3:0] {
        VERSION = 'd0,
        ID      = 'd1,
        SCRATCH = 'd2,
        MAGIC   = 'd3,
        PATTERN = 'd4,
        LEVEL   = 'd5,
        EMPTY   = 'd6,
        DATA    = 'd7,  // read pops the head
        USER    = 'd8   // head user, no pop
    } axf_reg_e;

    // data register pop sequence
    typedef enum logic [1:0] {
        POP_IDLE,
        POP_STROBE,
        POP_ACK
    } axf_pop_state_e;

    // per direction in the axi-lite adapter
    typedef enum logic [1:0] {
        IDLE,
        WAIT_ACK,
        RESP
    } axil_state_e;

endpackage

// ==== design/axis_fifo.sv ====
`timescale 1ns/100ps

`include "axil_fifo_defs.svh"

module axis_fifo #(
    parameter int DATA_WIDTH = `AXF_DATA_WIDTH,
    parameter int USER_WIDTH = `AXF_USER_WIDTH,
    parameter int FIFO_LEN   = `AXF_FIFO_LEN
) (
    input  logic                  clk_i,
    input  logic                  reset_ni,

    input  logic [DATA_WIDTH-1:0] s_axis_tdata_i,
    input  logic [USER_WIDTH-1:0] s_axis_tuser_i,
    input  logic                  s_axis_tlast_i,
    input  logic                  s_axis_tvalid_i,
    output logic                  s_axis_tfull_o,

    input  logic                  m_pop_i,
    output logic [DATA_WIDTH-1:0] m_data_o,
    output logic [USER_WIDTH-1:0] m_user_o,
    output logic                  m_last_o,
    output logic                  m_empty_o,
    output logic [31:0]           m_level_o
);

    localparam int ADDR_W = $clog2(FIFO_LEN);
    localparam logic [ADDR_W:0] DEPTH = (ADDR_W + 1)'(FIFO_LEN);

    logic [DATA_WIDTH-1:0] data_mem [FIFO_LEN];
    logic [USER_WIDTH-1:0] user_mem [FIFO_LEN];
    logic                  last_mem [FIFO_LEN];

    logic [ADDR_W:0] wr_ptr_q;
    logic [ADDR_W:0] rd_ptr_q;
    logic [ADDR_W:0] count_q;
    logic [ADDR_W:0] count_next;
    logic            full_q;
    logic            empty_q;
    logic            push;
    logic            pop;

    assign push = s_axis_tvalid_i && !full_q;  // dropped when full
    assign pop  = m_pop_i && !empty_q;

    always_comb begin
        count_next = count_q;
        if (push && !pop) begin
            count_next = count_q + 1'b1;
        end else if (pop && !push) begin
            count_next = count_q - 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            full_q   <= 1'b0;
            empty_q  <= 1'b1;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q <= count_next;
            full_q  <= (count_next == DEPTH);  // rises with the last free slot
            empty_q <= (count_next == '0);
        end
    end

    // storage, side by side
    always_ff @(posedge clk_i) begin
        if (push) begin
            data_mem[wr_ptr_q[ADDR_W-1:0]] <= s_axis_tdata_i;
            user_mem[wr_ptr_q[ADDR_W-1:0]] <= s_axis_tuser_i;
            last_mem[wr_ptr_q[ADDR_W-1:0]] <= s_axis_tlast_i;
        end
    end

    // first word falls through
    assign m_data_o = data_mem[rd_ptr_q[ADDR_W-1:0]];
    assign m_user_o = user_mem[rd_ptr_q[ADDR_W-1:0]];
    assign m_last_o = last_mem[rd_ptr_q[ADDR_W-1:0]];

    assign s_axis_tfull_o = full_q;
    assign m_empty_o      = empty_q;
    assign m_level_o      = {{(31 - ADDR_W){1'b0}}, count_q};

endmodule

// ==== design/axil_slave_if.sv ====
`timescale 1ns/100ps

`include "axil_fifo_defs.svh"

module axil_slave_if #(
    parameter int ADDR_WIDTH = `AXF_ADDR_WIDTH
) (
    input  logic                  clk_i,
    input  logic                  reset_ni,

    // write address
    input  logic [ADDR_WIDTH-1:0] s_axi_awaddr_i,
    input  logic                  s_axi_awvalid_i,
    output logic                  s_axi_awready_o,

    // write data, strobes ignored so every write is a full word
    input  logic [31:0]           s_axi_wdata_i,
    input  logic [3:0]            s_axi_wstrb_i,
    input  logic                  s_axi_wvalid_i,
    output logic                  s_axi_wready_o,

    // write response
    output logic [1:0]            s_axi_bresp_o,
    output logic                  s_axi_bvalid_o,
    input  logic                  s_axi_bready_i,

    // read address
    input  logic [ADDR_WIDTH-1:0] s_axi_araddr_i,
    input  logic                  s_axi_arvalid_i,
    output logic                  s_axi_arready_o,

    // read data
    output logic [31:0]           s_axi_rdata_o,
    output logic [1:0]            s_axi_rresp_o,
    output logic                  s_axi_rvalid_o,
    input  logic                  s_axi_rready_i,

    // register bus
    output logic                  rreq_o,
    output logic [ADDR_WIDTH-3:0] raddr_o,
    input  logic [31:0]           rdata_i,
    input  logic                  rack_i,
    output logic                  wreq_o,
    output logic [ADDR_WIDTH-3:0] waddr_o,
    output logic [31:0]           wdata_o,
    input  logic                  wack_i
);

    axil_fifo_pkg::axil_state_e rd_state_q;
    axil_fifo_pkg::axil_state_e wr_state_q;

    assign s_axi_bresp_o = 2'b00;  // always OKAY
    assign s_axi_rresp_o = 2'b00;

    // read side
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            rd_state_q      <= axil_fifo_pkg::IDLE;
            s_axi_arready_o <= 1'b0;
            s_axi_rvalid_o  <= 1'b0;
            rreq_o          <= 1'b0;
        end else begin
            case (rd_state_q)
                axil_fifo_pkg::IDLE: begin
                    if (s_axi_arvalid_i && s_axi_arready_o) begin
                        s_axi_arready_o <= 1'b0;
                        rreq_o          <= 1'b1;
                        rd_state_q      <= axil_fifo_pkg::WAIT_ACK;
                    end else begin
                        s_axi_arready_o <= 1'b1;
                    end
                end
                axil_fifo_pkg::WAIT_ACK: begin
                    rreq_o <= 1'b0;  // one cycle pulse
                    if (rack_i) begin
                        s_axi_rvalid_o <= 1'b1;
                        rd_state_q     <= axil_fifo_pkg::RESP;
                    end
                end
                axil_fifo_pkg::RESP: begin
                    if (s_axi_rready_i) begin
                        s_axi_rvalid_o <= 1'b0;
                        rd_state_q     <= axil_fifo_pkg::IDLE;
                    end
                end
                default: rd_state_q <= axil_fifo_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (s_axi_arvalid_i && s_axi_arready_o) begin
            raddr_o <= s_axi_araddr_i[ADDR_WIDTH-1:2];  // byte to word
        end
        if (rd_state_q == axil_fifo_pkg::WAIT_ACK && rack_i) begin
            s_axi_rdata_o <= rdata_i;
        end
    end

    // write side, AW and W only taken together
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_state_q      <= axil_fifo_pkg::IDLE;
            s_axi_awready_o <= 1'b0;
            s_axi_wready_o  <= 1'b0;
            s_axi_bvalid_o  <= 1'b0;
            wreq_o          <= 1'b0;
        end else begin
            case (wr_state_q)
                axil_fifo_pkg::IDLE: begin
                    if (s_axi_awready_o) begin
                        // both valids held, handshake on this edge
                        s_axi_awready_o <= 1'b0;
                        s_axi_wready_o  <= 1'b0;
                        wreq_o          <= 1'b1;
                        wr_state_q      <= axil_fifo_pkg::WAIT_ACK;
                    end else if (s_axi_awvalid_i && s_axi_wvalid_i) begin
                        s_axi_awready_o <= 1'b1;
                        s_axi_wready_o  <= 1'b1;
                    end
                end
                axil_fifo_pkg::WAIT_ACK: begin
                    wreq_o <= 1'b0;
                    if (wack_i) begin
                        s_axi_bvalid_o <= 1'b1;
                        wr_state_q     <= axil_fifo_pkg::RESP;
                    end
                end
                axil_fifo_pkg::RESP: begin
                    if (s_axi_bready_i) begin
                        s_axi_bvalid_o <= 1'b0;
                        wr_state_q     <= axil_fifo_pkg::IDLE;
                    end
                end
                default: wr_state_q <= axil_fifo_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_state_q == axil_fifo_pkg::IDLE && s_axi_awready_o) begin
            waddr_o <= s_axi_awaddr_i[ADDR_WIDTH-1:2];
            wdata_o <= s_axi_wdata_i;
        end
    end

endmodule

// ==== design/axis_axil_fifo.sv ====
`timescale 1ns/100ps

`include "axil_fifo_defs.svh"

module axis_axil_fifo (
    input  logic                       clk_i,
    input  logic                       reset_ni,

    // stream in
    input  logic [`AXF_DATA_WIDTH-1:0] s_axis_tdata_i,
    input  logic [`AXF_USER_WIDTH-1:0] s_axis_tuser_i,
    input  logic                       s_axis_tlast_i,
    input  logic                       s_axis_tvalid_i,
    output logic                       s_axis_tfull_o,

    // axi-lite slave
    input  logic [`AXF_ADDR_WIDTH-1:0] s_axi_awaddr_i,
    input  logic                       s_axi_awvalid_i,
    output logic                       s_axi_awready_o,
    input  logic [31:0]                s_axi_wdata_i,
    input  logic [3:0]                 s_axi_wstrb_i,
    input  logic                       s_axi_wvalid_i,
    output logic                       s_axi_wready_o,
    output logic [1:0]                 s_axi_bresp_o,
    output logic                       s_axi_bvalid_o,
    input  logic                       s_axi_bready_i,
    input  logic [`AXF_ADDR_WIDTH-1:0] s_axi_araddr_i,
    input  logic                       s_axi_arvalid_i,
    output logic                       s_axi_arready_o,
    output logic [31:0]                s_axi_rdata_o,
    output logic [1:0]                 s_axi_rresp_o,
    output logic                       s_axi_rvalid_o,
    input  logic                       s_axi_rready_i
);

    logic [`AXF_DATA_WIDTH-1:0] fifo_data;
    logic [`AXF_USER_WIDTH-1:0] fifo_user;
    logic                       fifo_empty;
    logic [31:0]                fifo_level;
    logic                       fifo_pop;

    logic                       rreq;
    logic [`AXF_ADDR_WIDTH-3:0] raddr;
    logic [31:0]                rdata_q;
    logic                       rack_q;
    logic                       wreq;
    logic [`AXF_ADDR_WIDTH-3:0] waddr;
    logic [31:0]                wdata;
    logic                       wack_q;

    logic [31:0]                scratch_q;
    logic                       data_pop;

    axil_fifo_pkg::axf_reg_e        rsel;
    axil_fifo_pkg::axf_reg_e        wsel;
    axil_fifo_pkg::axf_pop_state_e  pop_state_q;

    axis_fifo #(
        .DATA_WIDTH (`AXF_DATA_WIDTH),
        .USER_WIDTH (`AXF_USER_WIDTH),
        .FIFO_LEN   (`AXF_FIFO_LEN)
    ) u_fifo (
        .clk_i           (clk_i),
        .reset_ni        (reset_ni),
        .s_axis_tdata_i  (s_axis_tdata_i),
        .s_axis_tuser_i  (s_axis_tuser_i),
        .s_axis_tlast_i  (s_axis_tlast_i),
        .s_axis_tvalid_i (s_axis_tvalid_i),
        .s_axis_tfull_o  (s_axis_tfull_o),
        .m_pop_i         (fifo_pop),
        .m_data_o        (fifo_data),
        .m_user_o        (fifo_user),
        .m_last_o        (),            // last is not in the register map
        .m_empty_o       (fifo_empty),
        .m_level_o       (fifo_level)
    );

    axil_slave_if #(
        .ADDR_WIDTH (`AXF_ADDR_WIDTH)
    ) u_axil (
        .clk_i           (clk_i),
        .reset_ni        (reset_ni),
        .s_axi_awaddr_i  (s_axi_awaddr_i),
        .s_axi_awvalid_i (s_axi_awvalid_i),
        .s_axi_awready_o (s_axi_awready_o),
        .s_axi_wdata_i   (s_axi_wdata_i),
        .s_axi_wstrb_i   (s_axi_wstrb_i),
        .s_axi_wvalid_i  (s_axi_wvalid_i),
        .s_axi_wready_o  (s_axi_wready_o),
        .s_axi_bresp_o   (s_axi_bresp_o),
        .s_axi_bvalid_o  (s_axi_bvalid_o),
        .s_axi_bready_i  (s_axi_bready_i),
        .s_axi_araddr_i  (s_axi_araddr_i),
        .s_axi_arvalid_i (s_axi_arvalid_i),
        .s_axi_arready_o (s_axi_arready_o),
        .s_axi_rdata_o   (s_axi_rdata_o),
        .s_axi_rresp_o   (s_axi_rresp_o),
        .s_axi_rvalid_o  (s_axi_rvalid_o),
        .s_axi_rready_i  (s_axi_rready_i),
        .rreq_o          (rreq),
        .raddr_o         (raddr),
        .rdata_i         (rdata_q),
        .rack_i          (rack_q),
        .wreq_o          (wreq),
        .waddr_o         (waddr),
        .wdata_o         (wdata),
        .wack_i          (wack_q)
    );

    assign rsel = axil_fifo_pkg::axf_reg_e'(raddr);
    assign wsel = axil_fifo_pkg::axf_reg_e'(waddr);

    // data read with something to pop
    assign data_pop = rreq && (rsel == axil_fifo_pkg::DATA) && !fifo_empty;
    assign fifo_pop = (pop_state_q == axil_fifo_pkg::POP_STROBE);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            pop_state_q <= axil_fifo_pkg::POP_IDLE;
            rack_q      <= 1'b0;
        end else begin
            // pop strobe cycle is followed by the ack, all else acks next cycle
            rack_q <= (rreq && !data_pop) || fifo_pop;
            case (pop_state_q)
                axil_fifo_pkg::POP_IDLE: begin
                    if (data_pop) begin
                        pop_state_q <= axil_fifo_pkg::POP_STROBE;
                    end
                end
                axil_fifo_pkg::POP_STROBE: pop_state_q <= axil_fifo_pkg::POP_ACK;
                axil_fifo_pkg::POP_ACK:    pop_state_q <= axil_fifo_pkg::POP_IDLE;
                default:                   pop_state_q <= axil_fifo_pkg::POP_IDLE;
            endcase
        end
    end

    // read mux, latched in the request cycle
    always_ff @(posedge clk_i) begin
        if (rreq) begin
            case (rsel)
                axil_fifo_pkg::VERSION: rdata_q <= `AXF_VERSION;
                axil_fifo_pkg::ID:      rdata_q <= `AXF_CORE_ID;
                axil_fifo_pkg::SCRATCH: rdata_q <= scratch_q;
                axil_fifo_pkg::MAGIC:   rdata_q <= `AXF_MAGIC;
                axil_fifo_pkg::PATTERN: rdata_q <= `AXF_PATTERN;
                axil_fifo_pkg::LEVEL:   rdata_q <= fifo_level;
                axil_fifo_pkg::EMPTY:   rdata_q <= {31'd0, fifo_empty};
                axil_fifo_pkg::DATA: begin
                    rdata_q <= fifo_empty ? 32'd0
                             : {{(32 - `AXF_DATA_WIDTH){1'b0}}, fifo_data};
                end
                axil_fifo_pkg::USER: begin
                    rdata_q <= fifo_empty ? 32'd0
                             : {{(32 - `AXF_USER_WIDTH){1'b0}}, fifo_user};
                end
                default: rdata_q <= 32'd0;
            endcase
        end
    end

    // writes, only scratch is writable
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wack_q    <= 1'b0;
            scratch_q <= 32'd0;
        end else begin
            wack_q <= wreq;
            if (wreq && wsel == axil_fifo_pkg::SCRATCH) begin
                scratch_q <= wdata;
            end
        end
    end

endmodule

// ==== verif/tb_axis_axil_fifo.sv ====
`timescale 1ns/100ps

`include "axil_fifo_defs.svh"

module tb_axis_axil_fifo;

    localparam int RESET_CYCLES = 8;
    localparam int MAX_ENTRIES  = 80;

    typedef enum logic [1:0] {
        OP_PUSH,
        OP_WRITE,
        OP_READ
    } op_e;

    typedef struct packed {
        op_e                     op;
        axil_fifo_pkg::axf_reg_e addr;
        logic [31:0]             data;  // bit 16 is tlast for pushes
        logic                    user;
        logic [31:0]             exp;
    } entry_t;

    logic                       clk_i;
    logic                       reset_ni;
    logic [`AXF_DATA_WIDTH-1:0] s_axis_tdata_i;
    logic [`AXF_USER_WIDTH-1:0] s_axis_tuser_i;
    logic                       s_axis_tlast_i;
    logic                       s_axis_tvalid_i;
    logic                       s_axis_tfull_o;
    logic [`AXF_ADDR_WIDTH-1:0] s_axi_awaddr_i;
    logic                       s_axi_awvalid_i;
    logic                       s_axi_awready_o;
    logic [31:0]                s_axi_wdata_i;
    logic [3:0]                 s_axi_wstrb_i;
    logic                       s_axi_wvalid_i;
    logic                       s_axi_wready_o;
    logic [1:0]                 s_axi_bresp_o;
    logic                       s_axi_bvalid_o;
    logic                       s_axi_bready_i;
    logic [`AXF_ADDR_WIDTH-1:0] s_axi_araddr_i;
    logic                       s_axi_arvalid_i;
    logic                       s_axi_arready_o;
    logic [31:0]                s_axi_rdata_o;
    logic [1:0]                 s_axi_rresp_o;
    logic                       s_axi_rvalid_o;
    logic                       s_axi_rready_i;

    entry_t                     stim [MAX_ENTRIES];
    int                         num_entries = 0;
    int                         cycle_count = 0;
    logic [31:0]                lfsr_state;
    logic [`AXF_DATA_WIDTH:0]   model_q [$];  // {user, data} per stored word

    axis_axil_fifo uut (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // run limit scales with the table
    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= 40 * num_entries + RESET_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_count);
            $display("TB FAILED");
            $fatal(1);
        end
    end

    function automatic logic next_bit();
        logic out;
        out        = lfsr_state[0];
        lfsr_state = {1'b0, lfsr_state[31:1]} ^ (out ? 32'hd000_0001 : 32'h0);
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error: %s expected %h got %h", name, exp, got);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    task automatic add_entry(input op_e op, input axil_fifo_pkg::axf_reg_e addr,
                             input logic [31:0] data, input logic user,
                             input logic [31:0] exp);
        entry_t e;
        e.op                = op;
        e.addr              = addr;
        e.data              = data;
        e.user              = user;
        e.exp               = exp;
        stim[num_entries]   = e;
        num_entries         = num_entries + 1;
    endtask

    // expected read value from the model with a pop for DATA
    function automatic logic [31:0] expected_read(input entry_t e);
        logic [31:0] head;
        head = '0;
        if (model_q.size() != 0) begin
            head = 32'(model_q[0][`AXF_DATA_WIDTH-1:0]);
        end
        case (e.addr)
            axil_fifo_pkg::LEVEL: return 32'(model_q.size());
            axil_fifo_pkg::EMPTY: return {31'd0, model_q.size() == 0};
            axil_fifo_pkg::USER: begin
                return (model_q.size() == 0) ? 32'h0 : 32'(model_q[0][`AXF_DATA_WIDTH]);
            end
            axil_fifo_pkg::DATA: begin
                if (model_q.size() != 0) begin
                    void'(model_q.pop_front());
                end
                return head;
            end
            default: return e.exp;
        endcase
    endfunction

    task automatic stream_push(input logic [31:0] data, input logic user);
        logic [3:0] low;
        low = 4'(rand_bits(4));
        check_value("s_axis_tfull_o", 32'(s_axis_tfull_o),
                    32'(model_q.size() == `AXF_FIFO_LEN));
        s_axis_tdata_i  = {data[`AXF_DATA_WIDTH-1:4], low};
        s_axis_tuser_i  = user;
        s_axis_tlast_i  = data[16];
        s_axis_tvalid_i = 1'b1;  // stays high across back to back pushes
        if (model_q.size() < `AXF_FIFO_LEN) begin
            model_q.push_back({user, s_axis_tdata_i});
        end
        @(negedge clk_i);
    endtask

    task automatic axil_write(input axil_fifo_pkg::axf_reg_e addr, input logic [31:0] data);
        s_axi_awaddr_i  = {addr, 2'b00};
        s_axi_wdata_i   = data;
        s_axi_wstrb_i   = 4'hf;
        s_axi_awvalid_i = 1'b1;
        s_axi_wvalid_i  = 1'b1;
        while (!(s_axi_awready_o && s_axi_wready_o)) begin
            @(negedge clk_i);
        end
        @(negedge clk_i);  // pair taken on the edge just passed
        s_axi_awvalid_i = 1'b0;
        s_axi_wvalid_i  = 1'b0;
        while (!s_axi_bvalid_o) begin
            @(negedge clk_i);
        end
        if (next_bit()) begin
            @(negedge clk_i);
        end
        check_value("s_axi_bresp_o", 32'(s_axi_bresp_o), 32'h0);
        s_axi_bready_i = 1'b1;
        @(negedge clk_i);
        s_axi_bready_i = 1'b0;
        check_value("s_axi_bvalid_o", 32'(s_axi_bvalid_o), 32'h0);
    endtask

    task automatic axil_read(input axil_fifo_pkg::axf_reg_e addr, output logic [31:0] data);
        s_axi_araddr_i  = {addr, 2'b00};
        s_axi_arvalid_i = 1'b1;
        while (!s_axi_arready_o) begin
            @(negedge clk_i);
        end
        @(negedge clk_i);
        s_axi_arvalid_i = 1'b0;
        while (!s_axi_rvalid_o) begin
            @(negedge clk_i);
        end
        if (next_bit()) begin
            @(negedge clk_i);  // master stalls one cycle
        end
        data = s_axi_rdata_o;
        check_value("s_axi_rresp_o", 32'(s_axi_rresp_o), 32'h0);
        s_axi_rready_i = 1'b1;
        @(negedge clk_i);
        s_axi_rready_i = 1'b0;
        check_value("s_axi_rvalid_o", 32'(s_axi_rvalid_o), 32'h0);
    endtask

    task automatic apply_entry(input entry_t e);
        logic [31:0]             got;
        logic [31:0]             exp;
        axil_fifo_pkg::axf_reg_e reg_sel;
        reg_sel = e.addr;
        if (e.op == OP_PUSH) begin
            stream_push(e.data, e.user);
        end else if (e.op == OP_WRITE) begin
            s_axis_tvalid_i = 1'b0;
            axil_write(e.addr, e.data);
        end else begin
            s_axis_tvalid_i = 1'b0;
            exp = expected_read(e);
            axil_read(e.addr, got);
            check_value($sformatf("s_axi_rdata_o (%s)", reg_sel.name()), got, exp);
        end
    endtask

    task automatic build_table();
        add_entry(OP_READ,  axil_fifo_pkg::LEVEL,   32'h0, 1'b0, 32'h0);
        add_entry(OP_READ,  axil_fifo_pkg::EMPTY,   32'h0, 1'b0, 32'h0);
        add_entry(OP_READ,  axil_fifo_pkg::SCRATCH, 32'h0, 1'b0, 32'h0);
        add_entry(OP_READ,  axil_fifo_pkg::VERSION, 32'h0, 1'b0, `AXF_VERSION);
        add_entry(OP_READ,  axil_fifo_pkg::ID,      32'h0, 1'b0, `AXF_CORE_ID);
        add_entry(OP_READ,  axil_fifo_pkg::MAGIC,   32'h0, 1'b0, `AXF_MAGIC);
        add_entry(OP_READ,  axil_fifo_pkg::PATTERN, 32'h0, 1'b0, `AXF_PATTERN);
        add_entry(OP_WRITE, axil_fifo_pkg::SCRATCH, 32'ha5c3_1e0f, 1'b0, 32'h0);
        add_entry(OP_READ,  axil_fifo_pkg::SCRATCH, 32'h0, 1'b0, 32'ha5c3_1e0f);
        add_entry(OP_WRITE, axil_fifo_pkg::MAGIC,   32'h0, 1'b0, 32'h0);  // read only
        add_entry(OP_READ,  axil_fifo_pkg::MAGIC,   32'h0, 1'b0, `AXF_MAGIC);
        add_entry(OP_READ,  axil_fifo_pkg::SCRATCH, 32'h0, 1'b0, 32'ha5c3_1e0f);
        add_entry(OP_PUSH,  axil_fifo_pkg::DATA,    32'h0000_1110, 1'b1, 32'h0);
        add_entry(OP_PUSH,  axil_fifo_pkg::DATA,    32'h0000_2220, 1'b0, 32'h0);
        add_entry(OP_PUSH,  axil_fifo_pkg::DATA,    32'h0001_3330, 1'b1, 32'h0);
        add_entry(OP_READ,  axil_fifo_pkg::LEVEL,   32'h0, 1'b0, 32'h0);
        add_entry(OP_READ,  axil_fifo_pkg::EMPTY,   32'h0, 1'b0, 32'h0);
        add_entry(OP_READ,  axil_fifo_pkg::USER,    32'h0, 1'b0, 32'h0);
        add_entry(OP_READ,  axil_fifo_pkg::LEVEL,   32'h0, 1'b0, 32'h0);
        for (int i = 0; i < 3; i++) begin
            add_entry(OP_READ, axil_fifo_pkg::DATA,  32'h0, 1'b0, 32'h0);
            add_entry(OP_READ, axil_fifo_pkg::USER,  32'h0, 1'b0, 32'h0);
            add_entry(OP_READ, axil_fifo_pkg::LEVEL, 32'h0, 1'b0, 32'h0);
        end
        add_entry(OP_READ,  axil_fifo_pkg::EMPTY,   32'h0, 1'b0, 32'h0);
        add_entry(OP_READ,  axil_fifo_pkg::DATA,    32'h0, 1'b0, 32'h0);  // empty so no pop
        add_entry(OP_READ,  axil_fifo_pkg::LEVEL,   32'h0, 1'b0, 32'h0);
        // overfill by two so the last two drop
        for (int i = 0; i < `AXF_FIFO_LEN + 2; i++) begin
            add_entry(OP_PUSH, axil_fifo_pkg::DATA, 32'h0000_a000 | 32'(i << 4), i[0], 32'h0);
        end
        add_entry(OP_READ,  axil_fifo_pkg::LEVEL,   32'h0, 1'b0, 32'h0);
        add_entry(OP_READ,  axil_fifo_pkg::EMPTY,   32'h0, 1'b0, 32'h0);
        for (int i = 0; i < `AXF_FIFO_LEN; i++) begin
            add_entry(OP_READ, axil_fifo_pkg::DATA,  32'h0, 1'b0, 32'h0);
            add_entry(OP_READ, axil_fifo_pkg::LEVEL, 32'h0, 1'b0, 32'h0);
        end
        add_entry(OP_READ,  axil_fifo_pkg::DATA,    32'h0, 1'b0, 32'h0);
        add_entry(OP_READ,  axil_fifo_pkg::LEVEL,   32'h0, 1'b0, 32'h0);
        add_entry(OP_READ,  axil_fifo_pkg::EMPTY,   32'h0, 1'b0, 32'h0);
        add_entry(OP_WRITE, axil_fifo_pkg::SCRATCH, 32'h1234_5678, 1'b0, 32'h0);
        add_entry(OP_READ,  axil_fifo_pkg::SCRATCH, 32'h0, 1'b0, 32'h1234_5678);
    endtask

    initial begin
        lfsr_state      = 32'h5753b5e2;
        reset_ni        = 1'b0;
        s_axis_tdata_i  = '0;
        s_axis_tuser_i  = '0;
        s_axis_tlast_i  = 1'b0;
        s_axis_tvalid_i = 1'b0;
        s_axi_awaddr_i  = '0;
        s_axi_awvalid_i = 1'b0;
        s_axi_wdata_i   = '0;
        s_axi_wstrb_i   = '0;
        s_axi_wvalid_i  = 1'b0;
        s_axi_bready_i  = 1'b0;
        s_axi_araddr_i  = '0;
        s_axi_arvalid_i = 1'b0;
        s_axi_rready_i  = 1'b0;
        build_table();

        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        check_value("s_axis_tfull_o", 32'(s_axis_tfull_o), 32'h0);
        check_value("s_axi_awready_o", 32'(s_axi_awready_o), 32'h0);
        check_value("s_axi_wready_o", 32'(s_axi_wready_o), 32'h0);
        check_value("s_axi_arready_o", 32'(s_axi_arready_o), 32'h0);
        check_value("s_axi_bvalid_o", 32'(s_axi_bvalid_o), 32'h0);
        check_value("s_axi_rvalid_o", 32'(s_axi_rvalid_o), 32'h0);
        reset_ni = 1'b1;

        for (int i = 0; i < num_entries; i++) begin
            apply_entry(stim[i]);
        end
        @(negedge clk_i);
        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+design
design/axil_fifo_pkg.sv
design/axis_fifo.sv
design/axil_slave_if.sv
design/axis_axil_fifo.sv
verif/tb_axis_axil_fifo.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build with verilator, run, then look for the pass line in the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_axis_axil_fifo -Mdir obj_dir -o sim_tb \
    -f flist.f > build.log 2>&1 \
    || { cat build.log; echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1

grep -q "TB PASSED" sim.log \
    && echo "simulation passed, see sim.log" \
    && exit 0 \
    || { cat sim.log; echo "simulation failed, see sim.log"; exit 1; }
